/* sdramPkg.sv */
package sdramPkg;

  // --------------------------------------------------
  // bus address word
  // --------------------------------------------------
  typedef union packed {
    logic [31:0] raw;
    struct packed {
      logic [6:0]  region;
      logic [1:0]  bank;
      logic [12:0] row;
      logic [7:0]  column;   // 32-bit word within the row.
      logic [1:0]  byteSel;
    } fields;
  } busAddress_t;

  typedef enum logic [4:0] {
    stReset, stPowerWait,
    stInitPrecharge, stInitPrechargeWait,
    stInitRefresh1, stInitRefresh1Wait,
    stInitRefresh2, stInitRefresh2Wait,
    stModeLoad, stModeLoadWait,
    stIdle, stRefresh, stRefreshWait,
    stActivate, stActivateWait,
    stWriteLo, stWriteHi, stWriteRecover,
    stReadCmd, stReadBurst, stBurstStop,
    stClose, stCloseWait
  } seqState_t;

  // --------------------------------------------------
  // commands as {csN, rasN, casN, weN}
  // --------------------------------------------------
  localparam logic [3:0] cmdNop       = 4'b0111;
  localparam logic [3:0] cmdPrecharge = 4'b0010;
  localparam logic [3:0] cmdRefresh   = 4'b0001;
  localparam logic [3:0] cmdModeReg   = 4'b0000;
  localparam logic [3:0] cmdActivate  = 4'b0011;
  localparam logic [3:0] cmdRead      = 4'b0101;
  localparam logic [3:0] cmdWrite     = 4'b0100;
  localparam logic [3:0] cmdBurstStop = 4'b0110;

  // single writes, CL 2, sequential full-page bursts.
  localparam logic [12:0] modeRegValue = 13'b0_0010_0010_0111;

  localparam int casLatency = 2;

  localparam logic [12:0] prechargeAllA10 = 13'h0400;

  localparam int readFifoDepthLog2 = 8;   // one full-page burst.

endpackage

/* busFrontEnd.sv */
module busFrontEnd #(
  parameter logic [31:0] baseAddress = 32'h0000_0000
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  beginTransactionIn,
  input  logic                  endTransactionIn,
  input  logic                  readNotWriteIn,
  input  logic                  dataValidIn,
  input  logic [31:0]           addressDataIn,
  input  logic [3:0]            byteEnablesIn,
  input  logic [7:0]            burstSizeIn,
  input  logic                  accepted,
  input  logic                  writeDone,
  output logic                  mine,
  output logic                  readRequest,
  output logic                  writeRequest,
  output sdramPkg::busAddress_t address,
  output logic [7:0]            burstSize,
  output logic [3:0]            byteEnables,
  output logic [31:0]           writeData,
  output logic                  busyOut
);

  logic transactionActive;
  logic readNotWrite;
  logic beginSeen;   // fields registered, region known.
  logic writeBusy;

  assign mine    = transactionActive && (address.raw[31:25] == baseAddress[31:25]);
  assign busyOut = mine && writeBusy;

  always_ff @(posedge clock)
  begin
    if (beginTransactionIn)
    begin
      address.raw  <= addressDataIn;
      readNotWrite <= readNotWriteIn;
      byteEnables  <= byteEnablesIn;
      burstSize    <= burstSizeIn;
    end
    if (dataValidIn && writeBusy)
      writeData <= addressDataIn;   // the bus carries data after the address.
  end

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      transactionActive <= 1'b0;
      beginSeen         <= 1'b0;
      writeBusy         <= 1'b0;
      readRequest       <= 1'b0;
      writeRequest      <= 1'b0;
    end
    else
    begin
      beginSeen <= beginTransactionIn;
      if (beginTransactionIn)
        transactionActive <= 1'b1;
      else if (endTransactionIn)
        transactionActive <= 1'b0;
      if (beginTransactionIn)
        writeBusy <= ~readNotWriteIn;
      else if (writeDone)
        writeBusy <= 1'b0;
      // requests stay up until the sequencer takes them.
      if (accepted)
        readRequest <= 1'b0;
      else if (beginSeen && mine && readNotWrite)
        readRequest <= 1'b1;
      if (accepted)
        writeRequest <= 1'b0;
      else if (dataValidIn && mine && writeBusy)
        writeRequest <= 1'b1;
    end
  end

endmodule

/* initRefreshTimer.sv */
module initRefreshTimer #(
  parameter int systemClockInHz = 10000000
) (
  input  logic clock,
  input  logic reset,
  input  logic startPowerWait,
  input  logic startRefresh,
  output logic waitDone,
  output logic refreshDue
);

  localparam int powerWaitCycles     = systemClockInHz / 10000;              // 100 us.
  localparam int refreshWaitCycles   = (systemClockInHz / 1000000) * 70 / 1000 + 1;
  localparam int refreshPeriodCycles = (systemClockInHz / 1000) * 78 / 10000; // 7.8 us.

  localparam logic [19:0] powerWaitLoad   = 20'(powerWaitCycles - 1);
  localparam logic [19:0] refreshWaitLoad = 20'(refreshWaitCycles - 1);
  // idle reacts at once, the refresh command follows a cycle later.
  localparam logic [19:0] refreshPeriodLoad = 20'(refreshPeriodCycles - 2);

  logic [19:0] waitCount;
  logic        waitRunning;
  logic [19:0] periodCount;

  assign waitDone   = waitRunning && (waitCount == 20'd0);
  assign refreshDue = (periodCount == 20'd0);

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      waitRunning <= 1'b0;
      waitCount   <= 20'd0;
      periodCount <= refreshPeriodLoad;
    end
    else
    begin
      if (startPowerWait)
      begin
        waitRunning <= 1'b1;
        waitCount   <= powerWaitLoad;
      end
      else if (startRefresh)
      begin
        waitRunning <= 1'b1;
        waitCount   <= refreshWaitLoad;
      end
      else if (waitDone)
        waitRunning <= 1'b0;
      else if (waitRunning)
        waitCount <= waitCount - 20'd1;

      if (startRefresh)
        periodCount <= refreshPeriodLoad;
      else if (!refreshDue)
        periodCount <= periodCount - 20'd1;   // holds at zero until served.
    end
  end

endmodule

/* commandSequencer.sv */
module commandSequencer (
  input  logic                  clock,
  input  logic                  reset,
  input  logic                  waitDone,
  input  logic                  refreshDue,
  input  logic                  readRequest,
  input  logic                  writeRequest,
  input  sdramPkg::busAddress_t address,
  input  logic [7:0]            burstSize,
  input  logic [3:0]            byteEnables,
  input  logic [31:0]           writeData,
  input  logic                  fifoFull,
  output logic                  startPowerWait,
  output logic                  startRefresh,
  output logic                  accepted,
  output logic                  writeDone,
  output logic                  sdramInitBusy,
  output logic                  readCapture,
  output logic                  readFinished,
  output logic                  sdramCke,
  output logic                  sdramCsN,
  output logic                  sdramRasN,
  output logic                  sdramCasN,
  output logic                  sdramWeN,
  output logic [12:0]           sdramAddr,
  output logic [1:0]            sdramBa,
  output logic [1:0]            sdramDqmN,
  output logic [15:0]           sdramDataOut,
  output logic                  sdramDataDriven
);

  import sdramPkg::*;

  seqState_t             state;
  seqState_t             nextState;
  logic                  opWrite;
  logic [8:0]            halfCount;   // halves left in the read burst.
  logic [casLatency-1:0] captureDelay;
  logic                  captureLast;
  logic [3:0]            cmd;
  logic [12:0]           addrNext;
  logic [1:0]            dqmNext;

  assign startPowerWait = (state == stReset);
  assign startRefresh   = (state == stInitRefresh1) || (state == stInitRefresh2) ||
                          (state == stRefresh);
  assign accepted       = (state == stActivate);
  assign readCapture    = captureDelay[casLatency-1];
  assign readFinished   = captureLast && !readCapture;

  // --------------------------------------------------
  // state machine
  // --------------------------------------------------
  always_comb
  begin
    nextState = state;
    case (state)
      stReset:             nextState = stPowerWait;
      stPowerWait:         nextState = waitDone ? stInitPrecharge : state;
      stInitPrecharge:     nextState = stInitPrechargeWait;
      stInitPrechargeWait: nextState = stInitRefresh1;
      stInitRefresh1:      nextState = stInitRefresh1Wait;
      stInitRefresh1Wait:  nextState = waitDone ? stInitRefresh2 : state;
      stInitRefresh2:      nextState = stInitRefresh2Wait;
      stInitRefresh2Wait:  nextState = waitDone ? stModeLoad : state;
      stModeLoad:          nextState = stModeLoadWait;
      stModeLoadWait:      nextState = stIdle;
      stIdle:
      begin
        if (refreshDue)
          nextState = stRefresh;
        else if (writeRequest || (readRequest && !fifoFull))
          nextState = stActivate;
      end
      stRefresh:           nextState = stRefreshWait;
      stRefreshWait:       nextState = waitDone ? stIdle : state;
      stActivate:          nextState = stActivateWait;   // tRCD.
      stActivateWait:
      begin
        if (!opWrite)
          nextState = stReadCmd;
        else if (byteEnables[1:0] != 2'b00)
          nextState = stWriteLo;
        else if (byteEnables[3:2] != 2'b00)
          nextState = stWriteHi;
        else
          nextState = stWriteRecover;
      end
      stWriteLo:      nextState = (byteEnables[3:2] != 2'b00) ? stWriteHi : stWriteRecover;
      stWriteHi:      nextState = stWriteRecover;
      stWriteRecover: nextState = stClose;
      stReadCmd:      nextState = stReadBurst;
      stReadBurst:    nextState = (halfCount == 9'd0) ? stBurstStop : state;
      stBurstStop:    nextState = stClose;
      stClose:        nextState = stCloseWait;
      default:        nextState = stIdle;
    endcase
  end

  // --------------------------------------------------
  // command decode
  // --------------------------------------------------
  always_comb
  begin
    cmd      = cmdNop;
    addrNext = {4'b0000, address.fields.column, 1'b0};
    dqmNext  = 2'b00;
    case (state)
      stInitPrecharge, stClose:
      begin
        cmd      = cmdPrecharge;
        addrNext = prechargeAllA10;
      end
      stInitRefresh1, stInitRefresh2, stRefresh:
        cmd = cmdRefresh;
      stModeLoad:
      begin
        cmd      = cmdModeReg;
        addrNext = modeRegValue;
      end
      stActivate:
      begin
        cmd      = cmdActivate;
        addrNext = address.fields.row;
      end
      stWriteLo:
      begin
        cmd     = cmdWrite;
        dqmNext = ~byteEnables[1:0];
      end
      stWriteHi:
      begin
        cmd      = cmdWrite;
        addrNext = {4'b0000, address.fields.column, 1'b1};
        dqmNext  = ~byteEnables[3:2];
      end
      stReadCmd:   cmd = cmdRead;
      stBurstStop: cmd = cmdBurstStop;
      default:     cmd = cmdNop;
    endcase
  end

  always_ff @(posedge clock)
  begin
    if (reset)
    begin
      state           <= stReset;
      opWrite         <= 1'b0;
      halfCount       <= 9'd0;
      captureDelay    <= '0;
      captureLast     <= 1'b0;
      writeDone       <= 1'b0;
      sdramInitBusy   <= 1'b1;
      sdramCke        <= 1'b0;
      {sdramCsN, sdramRasN, sdramCasN, sdramWeN} <= cmdNop;
      sdramDataDriven <= 1'b0;
    end
    else
    begin
      state <= nextState;
      if (state == stIdle)
        opWrite <= writeRequest;
      if (state == stReadCmd)
        halfCount <= {burstSize, 1'b1};
      else if (state == stReadBurst)
        halfCount <= halfCount - 9'd1;
      captureDelay <= {captureDelay[casLatency-2:0], state == stReadBurst};
      captureLast  <= readCapture;
      writeDone    <= (state == stCloseWait) && opWrite;
      if (state == stModeLoadWait)
        sdramInitBusy <= 1'b0;
      sdramCke <= 1'b1;
      {sdramCsN, sdramRasN, sdramCasN, sdramWeN} <= cmd;
      sdramDataDriven <= (state == stWriteLo) || (state == stWriteHi);
    end
  end

  always_ff @(posedge clock)
  begin
    sdramAddr    <= addrNext;
    sdramBa      <= (state == stModeLoad) ? 2'b00 : address.fields.bank;
    sdramDqmN    <= dqmNext;
    sdramDataOut <= (state == stWriteHi) ? writeData[31:16] : writeData[15:0];
  end

endmodule

/* readBuffer.sv */
module readBuffer (
  input  logic        clock,
  input  logic        reset,
  input  logic [15:0] sdramDataIn,
  input  logic        readCapture,
  input  logic        readFinished,
  input  logic        busyIn,
  input  logic        mine,
  output logic        dataValidOut,
  output logic [31:0] addressDataOut,
  output logic        endTransactionOut,
  output logic        fifoFull
);

  import sdramPkg::*;

  localparam int depth = 2 ** readFifoDepthLog2;

  logic [31:0]                  fifoMem [depth];
  logic [readFifoDepthLog2-1:0] writePtr;
  logic [readFifoDepthLog2-1:0] readPtr;
  logic [readFifoDepthLog2:0]   fillCount;
  logic [15:0]                  lowHalf;
  logic                         highNext;   // next capture is the upper half.
  logic                         minePrev;
  logic                         endPending;
  logic                         fifoClear;
  logic                         fifoEmpty;
  logic                         push;
  logic                         pop;
  logic                         drained;

  assign fifoClear = minePrev && !mine;
  assign fifoEmpty = (fillCount == '0);
  assign fifoFull  = fillCount[readFifoDepthLog2];
  assign push      = readCapture && highNext;
  assign pop       = !busyIn && !fifoEmpty;
  assign drained   = endPending && fifoEmpty && !dataValidOut;

  always_ff @(posedge clock)
  begin
    if (push)
      fifoMem[writePtr] <= {sdramDataIn, lowHalf};
    if (readCapture && !highNext)
      lowHalf <= sdramDataIn;
    if (fifoClear)
      addressDataOut <= 32'h0000_0000;
    else if (!busyIn)
      addressDataOut <= pop ? fifoMem[readPtr] : 32'h0000_0000;   // held while busy.
  end

  // --------------------------------------------------
  // pointers and bus strobes
  // --------------------------------------------------
  always_ff @(posedge clock)
  begin
    if (reset || fifoClear)
    begin
      writePtr          <= '0;
      readPtr           <= '0;
      fillCount         <= '0;
      highNext          <= 1'b0;
      endPending        <= 1'b0;
      dataValidOut      <= 1'b0;
      endTransactionOut <= 1'b0;
    end
    else
    begin
      if (readCapture)
        highNext <= !highNext;
      if (push)
        writePtr <= writePtr + 1'b1;
      if (pop)
        readPtr <= readPtr + 1'b1;
      case ({push, pop})
        2'b10:   fillCount <= fillCount + 1'b1;
        2'b01:   fillCount <= fillCount - 1'b1;
        default: fillCount <= fillCount;
      endcase
      if (!busyIn)
        dataValidOut <= !fifoEmpty;
      endTransactionOut <= drained;
      if (readFinished)
        endPending <= 1'b1;
      else if (drained)
        endPending <= 1'b0;
    end
  end

  always_ff @(posedge clock)
  begin
    if (reset)
      minePrev <= 1'b0;
    else
      minePrev <= mine;
  end

endmodule

/* sdramController.sv */
module sdramController #(
  parameter int          systemClockInHz = 10000000,
  parameter logic [31:0] baseAddress     = 32'h0000_0000
) (
  input  logic        clock,
  input  logic        reset,
  output logic        sdramInitBusy,
  // bus side.
  input  logic        beginTransactionIn,
  input  logic        endTransactionIn,
  input  logic        readNotWriteIn,
  input  logic        dataValidIn,
  input  logic        busyIn,
  input  logic [31:0] addressDataIn,
  input  logic [3:0]  byteEnablesIn,
  input  logic [7:0]  burstSizeIn,
  output logic        endTransactionOut,
  output logic        dataValidOut,
  output logic        busyOut,
  output logic [31:0] addressDataOut,
  // sdram pins.
  output logic        sdramClk,
  output logic        sdramCke,
  output logic        sdramCsN,
  output logic        sdramRasN,
  output logic        sdramCasN,
  output logic        sdramWeN,
  output logic [1:0]  sdramDqmN,
  output logic [12:0] sdramAddr,
  output logic [1:0]  sdramBa,
  output logic [15:0] sdramDataOut,
  output logic        sdramDataDriven,
  input  logic [15:0] sdramDataIn
);

  import sdramPkg::*;

  busAddress_t address;
  logic        mine;
  logic        readRequest;
  logic        writeRequest;
  logic [7:0]  burstSize;
  logic [3:0]  byteEnables;
  logic [31:0] writeData;
  logic        accepted;
  logic        writeDone;
  logic        startPowerWait;
  logic        startRefresh;
  logic        waitDone;
  logic        refreshDue;
  logic        readCapture;
  logic        readFinished;
  logic        fifoFull;

  assign sdramClk = clock;

  busFrontEnd #(.baseAddress(baseAddress)) frontEnd (.*);

  initRefreshTimer #(.systemClockInHz(systemClockInHz)) timer (.*);

  commandSequencer sequencer (.*);

  readBuffer buffer (.*);

endmodule

/* sdramModel.sv */
module sdramModel (
  input  logic        clock,
  input  logic        cke,
  input  logic        csN,
  input  logic        rasN,
  input  logic        casN,
  input  logic        weN,
  input  logic [12:0] addr,
  input  logic [1:0]  ba,
  input  logic [1:0]  dqmN,
  input  logic [15:0] dataWrite,
  input  logic        dataDriven,
  output logic [15:0] dataRead
);

  timeunit 1ns;
  timeprecision 1ns;

  import sdramPkg::*;

  logic [15:0] mem [int];
  logic [12:0] openRow [4];
  logic [3:0]  cmdLog [4];   // first commands after power-up.
  logic [12:0] modeSeen;
  int          cmdLogged;
  int          refreshCount;
  int          activateCount;
  logic        reading;
  logic [1:0]  readBank;
  logic [8:0]  readCol;
  wire  [3:0]  cmd = {csN, rasN, casN, weN};

  function automatic int keyOf(logic [1:0] b, logic [12:0] r, logic [8:0] c);
    return int'({b, r, c});
  endfunction

  // unwritten cells return a pattern of the whole key.
  function automatic logic [15:0] readHalf(int key);
    logic [31:0] k;
    k = 32'(key);
    if (mem.exists(key))
      return mem[key];
    return k[15:0] ^ {k[23:16], k[23:16]};
  endfunction

  initial
  begin
    cmdLogged     = 0;
    refreshCount  = 0;
    activateCount = 0;
    reading       = 1'b0;
    dataRead      = 16'h0000;
  end

  always @(posedge clock)
  begin : commandDecode
    int          key;
    logic [15:0] half;
    logic [15:0] data;
    if (reading)
    begin
      dataRead <= readHalf(keyOf(readBank, openRow[readBank], readCol));
      readCol  <= readCol + 9'd1;   // wraps within the row.
    end
    if (cke === 1'b1 && cmd !== cmdNop)
    begin
      if (cmdLogged < 4)
      begin
        cmdLog[cmdLogged] = cmd;
        cmdLogged++;
      end
      case (cmd)
        cmdActivate:
        begin
          openRow[ba] <= addr;
          activateCount++;
        end
        cmdRefresh: refreshCount++;
        cmdModeReg: modeSeen <= addr;
        cmdRead:
        begin
          reading  <= 1'b1;
          readBank <= ba;
          readCol  <= addr[8:0];
        end
        cmdBurstStop, cmdPrecharge: reading <= 1'b0;
        cmdWrite:
        begin
          key  = keyOf(ba, openRow[ba], addr[8:0]);
          half = readHalf(key);
          data = (dataDriven === 1'b1) ? dataWrite : 16'hxxxx;   // undriven bus floats.
          if (!dqmN[0])
            half[7:0] = data[7:0];
          if (!dqmN[1])
            half[15:8] = data[15:8];
          mem[key] = half;
        end
        default: ;
      endcase
    end
  end

endmodule

/* sdramController_asserts.sv */
module sdramControllerAsserts (
  input logic        clock,
  input logic        reset,
  input logic        sdramCsN,
  input logic        sdramRasN,
  input logic        sdramCasN,
  input logic        sdramWeN,
  input logic        sdramInitBusy,
  input logic        busyIn,
  input logic        dataValidOut,
  input logic [31:0] addressDataOut
);

  timeunit 1ns;
  timeprecision 1ns;

  import sdramPkg::*;

  wire [3:0] cmd = {sdramCsN, sdramRasN, sdramCasN, sdramWeN};

  nopInReset: assert property (@(posedge clock) reset && $past(reset) |-> cmd == cmdNop)
    else $error("command bus not NOP during reset");

  noActivateInInit: assert property (@(posedge clock) disable iff (reset)
    sdramInitBusy |-> cmd != cmdActivate)
    else $error("activate issued during initialisation");

  // a busy cycle freezes the word on the bus.
  holdWhileBusy: assert property (@(posedge clock) disable iff (reset)
    $past(busyIn) |-> $stable(dataValidOut) && $stable(addressDataOut))
    else $error("bus output changed while busyIn was high");

endmodule

bind sdramController sdramControllerAsserts asserts (.*);

/* tb_sdramController.sv */
module tb_sdramController;

  timeunit 1ns;
  timeprecision 1ns;

  import sdramPkg::*;

  localparam int          clockHz       = 10000000;
  localparam logic [31:0] base          = 32'h0200_0000;
  localparam int          initCycles    = clockHz / 10000 + 100;
  localparam int          refreshCycles = 78;   // 7.8 us at 10 MHz.
  localparam int          idlePeriods   = 40;

  typedef struct {
    bit          isRead;
    logic [31:0] addr;
    logic [3:0]  be;
    logic [7:0]  burst;   // words minus one.
    logic [31:0] dataSeed;
    bit          ignore;  // not addressed to the DUT.
  } testEntry_t;

  logic        clock;
  logic        reset;
  logic        beginTransactionIn;
  logic        endTransactionIn;
  logic        readNotWriteIn;
  logic        dataValidIn;
  logic        busyIn;
  logic [31:0] addressDataIn;
  logic [3:0]  byteEnablesIn;
  logic [7:0]  burstSizeIn;
  logic        sdramInitBusy;
  logic        endTransactionOut;
  logic        dataValidOut;
  logic        busyOut;
  logic [31:0] addressDataOut;
  logic        sdramClk;
  logic        sdramCke;
  logic        sdramCsN;
  logic        sdramRasN;
  logic        sdramCasN;
  logic        sdramWeN;
  logic [1:0]  sdramDqmN;
  logic [12:0] sdramAddr;
  logic [1:0]  sdramBa;
  logic [15:0] sdramDataOut;
  logic        sdramDataDriven;
  logic [15:0] sdramDataIn;

  int          seed = 32'h06d3_1787;
  int          errors;
  int          checks;
  int          endPulses;
  int          busyHigh;
  bit          tableBuilt;
  testEntry_t  tests[$];
  logic [31:0] refMem [int];
  logic [31:0] received[$];

  sdramController #(.systemClockInHz(clockHz), .baseAddress(base)) dut (.*);

  sdramModel memory (
    .clock(sdramClk), .cke(sdramCke), .csN(sdramCsN), .rasN(sdramRasN),
    .casN(sdramCasN), .weN(sdramWeN), .addr(sdramAddr), .ba(sdramBa),
    .dqmN(sdramDqmN), .dataWrite(sdramDataOut), .dataDriven(sdramDataDriven),
    .dataRead(sdramDataIn)
  );

  initial
  begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  // bus monitor sampled mid-cycle.
  always @(negedge clock)
  begin
    if (dataValidOut && !busyIn)
      received.push_back(addressDataOut);
    if (endTransactionOut)
      endPulses++;
    if (busyOut)
      busyHigh++;
  end

  task automatic nextCycle();
    @(posedge clock);
    #5;
  endtask

  task automatic checkValue(string what, logic [31:0] got, logic [31:0] expected);
    checks++;
    if (got !== expected)
    begin
      errors++;
      $display("ERROR at %0t ns: %s is %h, expected %h", $time, what, got, expected);
    end
  endtask

  function automatic logic [31:0] makeAddr(logic [1:0] bank, logic [12:0] row,
                                           logic [7:0] col);
    return {base[31:25], bank, row, col, 2'b00};
  endfunction

  function automatic void addTest(bit isRead, logic [31:0] addr, logic [3:0] be,
                                  logic [7:0] burst, logic [31:0] dataSeed, bit ignore);
    testEntry_t t;
    t.isRead   = isRead;
    t.addr     = addr;
    t.be       = be;
    t.burst    = burst;
    t.dataSeed = dataSeed;
    t.ignore   = ignore;
    tests.push_back(t);
  endfunction

  function automatic void buildTable();
    addTest(0, makeAddr(2'd1, 13'd5, 8'd10), 4'hf, 8'd0, 32'h1234_5678, 0);
    addTest(1, makeAddr(2'd1, 13'd5, 8'd10), 4'hf, 8'd0, 32'h0, 0);
    addTest(0, makeAddr(2'd1, 13'd5, 8'd10), 4'b0100, 8'd0, 32'hcafe_f00d, 0);
    addTest(0, makeAddr(2'd1, 13'd5, 8'd10), 4'b1001, 8'd0, 32'h5a5a_a5a5, 0);
    addTest(1, makeAddr(2'd1, 13'd5, 8'd10), 4'hf, 8'd0, 32'h0, 0);
    for (int c = 0; c < 8; c++)
      addTest(0, makeAddr(2'd0, 13'd3, 8'(20 + c)), 4'hf, 8'd0, 32'(c * 32'h0101_0101), 0);
    addTest(1, makeAddr(2'd0, 13'd3, 8'd20), 4'hf, 8'd7, 32'h0, 0);
    // last two words of the row, then the first two.
    addTest(0, makeAddr(2'd2, 13'd9, 8'd254), 4'hf, 8'd0, 32'haaaa_0001, 0);
    addTest(0, makeAddr(2'd2, 13'd9, 8'd255), 4'hf, 8'd0, 32'haaaa_0002, 0);
    addTest(0, makeAddr(2'd2, 13'd9, 8'd0), 4'hf, 8'd0, 32'haaaa_0003, 0);
    addTest(0, makeAddr(2'd2, 13'd9, 8'd1), 4'hf, 8'd0, 32'haaaa_0004, 0);
    addTest(1, makeAddr(2'd2, 13'd9, 8'd254), 4'hf, 8'd3, 32'h0, 0);
    addTest(0, 32'h0400_0010, 4'hf, 8'd0, 32'hdead_beef, 1);
    addTest(1, 32'h0400_0010, 4'hf, 8'd3, 32'h0, 1);
  endfunction

  task automatic runWrite(testEntry_t t);
    logic [31:0] data;
    logic [31:0] old;
    int          key;
    int          waited;
    data = t.dataSeed ^ $random(seed);
    busyHigh = 0;
    beginTransactionIn = 1'b1;
    readNotWriteIn     = 1'b0;
    addressDataIn      = t.addr;
    byteEnablesIn      = t.be;
    burstSizeIn        = 8'd0;
    nextCycle();
    beginTransactionIn = 1'b0;
    dataValidIn        = 1'b1;
    addressDataIn      = data;
    nextCycle();
    dataValidIn   = 1'b0;
    addressDataIn = 32'h0000_0000;
    waited = 0;
    while (busyOut && waited < 300)
    begin
      nextCycle();
      waited++;
    end
    if (waited == 300)
    begin
      errors++;
      $display("busyOut never fell after the write at %0t ns", $time);
    end
    if (t.ignore)
    begin
      repeat (20) nextCycle();
      checkValue("busyOut cycles", 32'(busyHigh), 32'd0);
    end
    else
    begin
      checkValue("busyOut rose", 32'(busyHigh > 0), 32'd1);
      key = int'(t.addr[24:2]);
      old = refMem.exists(key) ? refMem[key] : 32'h0000_0000;
      for (int b = 0; b < 4; b++)
        if (t.be[b])
          old[b*8 +: 8] = data[b*8 +: 8];
      refMem[key] = old;
    end
    endTransactionIn = 1'b1;
    nextCycle();
    endTransactionIn = 1'b0;
    nextCycle();
  endtask

  task automatic runRead(testEntry_t t);
    int          words;
    int          limit;
    int          waited;
    int          key;
    logic [31:0] r;
    logic [7:0]  col;
    words = int'(t.burst) + 1;
    limit = t.ignore ? 20 : 300 + 2 * words;
    received.delete();
    endPulses = 0;
    busyHigh  = 0;
    beginTransactionIn = 1'b1;
    readNotWriteIn     = 1'b1;
    addressDataIn      = t.addr;
    byteEnablesIn      = t.be;
    burstSizeIn        = t.burst;
    nextCycle();
    beginTransactionIn = 1'b0;
    addressDataIn      = 32'h0000_0000;
    waited = 0;
    while (endPulses == 0 && waited < limit)
    begin
      r = $random(seed);
      busyIn = r[0];
      nextCycle();
      waited++;
    end
    busyIn = 1'b0;
    repeat (4) nextCycle();
    if (t.ignore)
    begin
      checkValue("endTransactionOut pulses", 32'(endPulses), 32'd0);
      checkValue("words delivered", 32'(received.size()), 32'd0);
      checkValue("busyOut cycles", 32'(busyHigh), 32'd0);
    end
    else if (waited == limit)
    begin
      errors++;
      $display("read at %h never ended with endTransactionOut", t.addr);
    end
    else
    begin
      checkValue("endTransactionOut pulses", 32'(endPulses), 32'd1);
      checkValue("words delivered", 32'(received.size()), 32'(words));
      for (int i = 0; i < words && i < received.size(); i++)
      begin
        col = t.addr[9:2] + i[7:0];   // wraps within the row.
        key = int'({t.addr[24:10], col});
        if (refMem.exists(key))
          checkValue($sformatf("read word %0d", i), received[i], refMem[key]);
        else
        begin
          errors++;
          $display("no reference value for read word %0d", i);
        end
      end
    end
    endTransactionIn = 1'b1;
    nextCycle();
    endTransactionIn = 1'b0;
    nextCycle();
  endtask

  // --------------------------------------------------
  // watchdog
  // --------------------------------------------------
  initial
  begin : watchdog
    int limit;
    wait (tableBuilt);
    limit = initCycles + idlePeriods * refreshCycles + 100;
    foreach (tests[i])
      limit += 300 + 2 * (int'(tests[i].burst) + 1);
    repeat (limit) @(posedge clock);
    $display("watchdog expired after %0d cycles", limit);
    $display("Some tests failed");
    $finish;
  end

  initial
  begin : mainSequence
    int errorsBefore;
    int activatesBefore;
    int refreshesBefore;
    int waited;
    int delta;
    reset              = 1'b1;
    beginTransactionIn = 1'b0;
    endTransactionIn   = 1'b0;
    readNotWriteIn     = 1'b0;
    dataValidIn        = 1'b0;
    busyIn             = 1'b0;
    addressDataIn      = 32'h0000_0000;
    byteEnablesIn      = 4'h0;
    burstSizeIn        = 8'd0;
    errors = 0;
    checks = 0;
    buildTable();
    tableBuilt = 1'b1;
    repeat (8) nextCycle();

    errorsBefore = errors;
    checkValue("sdramCke in reset", 32'(sdramCke), 32'd0);
    checkValue("init busy in reset", 32'(sdramInitBusy), 32'd1);
    checkValue("command in reset", 32'({sdramCsN, sdramRasN, sdramCasN, sdramWeN}),
               32'(cmdNop));
    checkValue("bus strobes in reset", 32'({busyOut, dataValidOut, endTransactionOut}),
               32'd0);
    checkValue("data driven in reset", 32'(sdramDataDriven), 32'd0);
    $display("reset state: %s", (errors == errorsBefore) ? "pass" : "FAILED");
    reset = 1'b0;

    // --------------------------------------------------
    // initialisation
    // --------------------------------------------------
    waited = 0;
    while (sdramInitBusy && waited < initCycles)
    begin
      nextCycle();
      waited++;
    end
    errorsBefore = errors;
    checkValue("init busy fell", 32'(sdramInitBusy), 32'd0);
    checkValue("commands logged", 32'(memory.cmdLogged), 32'd4);
    checkValue("init cmd 0", 32'(memory.cmdLog[0]), 32'(cmdPrecharge));
    checkValue("init cmd 1", 32'(memory.cmdLog[1]), 32'(cmdRefresh));
    checkValue("init cmd 2", 32'(memory.cmdLog[2]), 32'(cmdRefresh));
    checkValue("init cmd 3", 32'(memory.cmdLog[3]), 32'(cmdModeReg));
    checkValue("mode register", 32'(memory.modeSeen), 32'(modeRegValue));
    $display("init sequence: %s", (errors == errorsBefore) ? "pass" : "FAILED");

    foreach (tests[i])
    begin
      errorsBefore    = errors;
      activatesBefore = memory.activateCount;
      if (tests[i].isRead)
        runRead(tests[i]);
      else
        runWrite(tests[i]);
      if (tests[i].ignore)
        checkValue("activates", 32'(memory.activateCount - activatesBefore), 32'd0);
      $display("test %0d %s %h: %s", i, tests[i].isRead ? "read " : "write", tests[i].addr,
               (errors == errorsBefore) ? "pass" : "FAILED");
    end

    errorsBefore    = errors;
    refreshesBefore = memory.refreshCount;
    repeat (idlePeriods * refreshCycles) nextCycle();
    delta = memory.refreshCount - refreshesBefore;
    checkValue("refresh count in 38..42", 32'(delta >= 38 && delta <= 42), 32'd1);
    $display("idle refresh, %0d refreshes: %s", delta,
             (errors == errorsBefore) ? "pass" : "FAILED");

    $display("%0d tests, %0d checks, %0d errors", tests.size() + 3, checks, errors);
    if (errors == 0)
      $display("All tests passed");
    else
      $display("Some tests failed");
    $finish;
  end

endmodule

/* list.f */
sdramPkg.sv
busFrontEnd.sv
initRefreshTimer.sv
commandSequencer.sv
readBuffer.sv
sdramController.sv
sdramModel.sv
sdramController_asserts.sv
tb_sdramController.sv

/* Makefile */
TOP = tb_sdramController

all: run

run:
	verilator --binary --timing --assert -f list.f --top-module $(TOP)
	./obj_dir/V$(TOP) | tee sim.log
	@! grep -q "Some tests failed" sim.log
	@grep -q "All tests passed" sim.log

lint:
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all run lint clean
